//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = macTb
FILELIST  = list.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- list.f
source/macPkg.sv
source/macDecoder.sv
source/macSequencer.sv
source/macStepCounter.sv
source/macMultiplier.sv
source/macAccumulator.sv
source/macRegFile.sv
source/macTop.sv
sim/macChecker.sv
sim/macTb.sv

//--- sim/macChecker.sv
module macChecker (
  input  logic            DSPCLK,
  input  logic            rst,
  input  macPkg::wbReq    req,
  input  macPkg::wbRsp    rsp,
  input  macPkg::dataWord expData,
  input  logic            runDone,
  output int              errorCount,
  output int              ackCount
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // acknowledge monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ack lasts exactly one cycle, so the falling edge sees each transfer once
  always @(negedge DSPCLK) begin
    if (rst) begin
      errorCount <= 0;
      ackCount   <= 0;
    end else if (rsp.ack) begin
      ackCount <= ackCount + 1;
      if (!(req.cyc && req.stb)) begin
        $display("row %0d: acknowledge arrived with no request on the bus", ackCount);
        errorCount <= errorCount + 1;
      end else if (req.we) begin
        $display("row %0d: write of %h to address %0d acknowledged",
                 ackCount, req.dat, req.adr);
      end else if (rsp.dat !== expData) begin
        $display("CHECK FAILED at time %0t: rsp.dat is %h, expected %h (row %0d, address %0d)",
                 $time, rsp.dat, expData, ackCount, req.adr);
        errorCount <= errorCount + 1;
      end else begin
        $display("row %0d: read of address %0d returned %h as expected",
                 ackCount, req.adr, rsp.dat);
      end
    end
  end

  // closing summary, printed once the driver has run out of rows
  always @(posedge runDone) begin
    $display("%0d transfers seen, %0d errors", ackCount, errorCount);
  end

endmodule

//--- sim/macTb.sv
module macTb;

  typedef struct packed {
    logic            we;
    macPkg::regAddr  adr;
    macPkg::dataWord dat;
    macPkg::dataWord expData;  // only meaningful for reads
  } tableRow;

  logic            DSPCLK;
  logic            rst;
  macPkg::wbReq    req;
  macPkg::wbRsp    rsp;
  macPkg::dataWord expData;
  logic            runDone;
  logic            tableReady;
  int              errorCount;
  int              ackCount;
  tableRow         rowTable [$];

  // reference copy of the registers, both banks
  macPkg::dataWord mx0M [2];
  macPkg::dataWord mx1M [2];
  macPkg::dataWord my0M [2];
  macPkg::dataWord my1M [2];
  macPkg::accWord  mrM  [2];
  logic [9:0]      cmdM;
  logic            bankM;

  macTop macTop_inst (.DSPCLK(DSPCLK), .rst(rst), .req(req), .rsp(rsp));

  macChecker checkerInst (
    .DSPCLK(DSPCLK), .rst(rst), .req(req), .rsp(rsp), .expData(expData),
    .runDone(runDone), .errorCount(errorCount), .ackCount(ackCount)
  );

  initial begin
    DSPCLK = 1'b0;
    forever #20 DSPCLK = ~DSPCLK;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // arithmetic model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic macPkg::accWord macResult(input logic [3:0] amf, input macPkg::dataWord x,
                                               input macPkg::dataWord y, input macPkg::accWord mr);
    logic   msub;
    logic   mzero;
    logic   rnd;
    logic   ux;
    logic   uy;
    longint xv;
    longint yv;
    longint base;
    longint res;
    msub  = (amf == 4'b0011) || (amf[3:2] == 2'b11);
    mzero = (amf == 4'b0001) || (amf[3:2] == 2'b01);
    rnd   = (amf[3:2] == 2'b00);
    ux    = amf[1] && !rnd;
    uy    = amf[0] && !rnd;
    xv    = ux ? longint'(x) : longint'($signed(x));
    yv    = uy ? longint'(y) : longint'($signed(y));
    base  = mzero ? 64'sd0 : longint'(mr);
    res   = msub ? base - xv * yv : base + xv * yv;
    if (rnd) begin
      res = res + 64'sd32768;  // half of an MR1 step
      res = res & ~64'hFFFF;
    end
    return res[39:0];  // wraps at 40 bits
  endfunction

  task automatic runCommand(input macPkg::dataWord dat);
    macPkg::dataWord x;
    macPkg::dataWord y;
    bankM = dat[0];  // the command's own bank applies to its operands
    cmdM  = dat[9:0];
    case (dat[5:3])
      3'b001:  x = mx1M[bankM];
      3'b011:  x = mrM[bankM][15:0];
      3'b100:  x = mrM[bankM][31:16];
      3'b101:  x = {{8{mrM[bankM][39]}}, mrM[bankM][39:32]};
      default: x = mx0M[bankM];
    endcase
    case (dat[2:1])
      2'b00:   y = my0M[bankM];
      2'b01:   y = my1M[bankM];
      2'b10:   y = mrM[bankM][31:16];
      default: y = '0;
    endcase
    mrM[bankM] = macResult(dat[9:6], x, y, mrM[bankM]);
  endtask

  function automatic macPkg::dataWord readModel(input macPkg::regAddr adr);
    case (adr)
      macPkg::ADR_MX0: return mx0M[bankM];
      macPkg::ADR_MX1: return mx1M[bankM];
      macPkg::ADR_MY0: return my0M[bankM];
      macPkg::ADR_MY1: return my1M[bankM];
      macPkg::ADR_CMD: return {6'b0, cmdM};
      macPkg::ADR_MR0: return mrM[bankM][15:0];
      macPkg::ADR_MR1: return mrM[bankM][31:16];
      default:         return {{8{mrM[bankM][39]}}, mrM[bankM][39:32]};
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic addRow(input logic we, input macPkg::regAddr adr, input macPkg::dataWord dat);
    tableRow row;
    row.we      = we;
    row.adr     = adr;
    row.dat     = dat;
    row.expData = '0;
    if (we) begin
      case (adr)
        macPkg::ADR_MX0: mx0M[bankM] = dat;
        macPkg::ADR_MX1: mx1M[bankM] = dat;
        macPkg::ADR_MY0: my0M[bankM] = dat;
        macPkg::ADR_MY1: my1M[bankM] = dat;
        macPkg::ADR_CMD: runCommand(dat);
        default: ;
      endcase
    end else begin
      row.expData = readModel(adr);
    end
    rowTable.push_back(row);
  endtask

  function automatic macPkg::dataWord packCmd(input logic [3:0] amf, input logic [2:0] xop,
                                              input logic [1:0] yop, input logic shadow);
    return {6'b0, amf, xop, yop, shadow};
  endfunction

  function automatic logic [3:0] pickAmf(input int unsigned k);
    case (k % 6)
      0:       return 4'b0101;
      1:       return 4'b1000;
      2:       return 4'b1100;
      3:       return 4'b0110;
      4:       return 4'b0111;
      default: return 4'b1011;
    endcase
  endfunction

  function automatic logic [2:0] pickXop(input int unsigned k);
    case (k % 4)
      0:       return 3'b000;
      1:       return 3'b001;
      2:       return 3'b011;
      default: return 3'b100;
    endcase
  endfunction

  task automatic readMr();
    addRow(1'b0, macPkg::ADR_MR0, '0);
    addRow(1'b0, macPkg::ADR_MR1, '0);
    addRow(1'b0, macPkg::ADR_MR2, '0);
  endtask

  task automatic buildTable();
    for (int b = 0; b < 2; b++) begin
      mx0M[b] = '0;
      mx1M[b] = '0;
      my0M[b] = '0;
      my1M[b] = '0;
      mrM[b]  = '0;
    end
    cmdM  = '0;
    bankM = 1'b0;
    readMr();  // reset state
    addRow(1'b1, macPkg::ADR_MX0, 16'hFED4);  // -300 times -1234
    addRow(1'b1, macPkg::ADR_MY0, 16'hFB2E);
    addRow(1'b1, macPkg::ADR_CMD, packCmd(4'b0101, 3'b000, 2'b00, 1'b0));
    readMr();
    addRow(1'b0, macPkg::ADR_MX0, '0);
    addRow(1'b0, macPkg::ADR_CMD, '0);
    addRow(1'b1, macPkg::ADR_MX1, 16'h7FFF);
    addRow(1'b1, macPkg::ADR_MY1, 16'h7FFF);
    addRow(1'b1, macPkg::ADR_CMD, packCmd(4'b1000, 3'b001, 2'b01, 1'b0));
    readMr();
    addRow(1'b1, macPkg::ADR_CMD, packCmd(4'b1100, 3'b100, 2'b10, 1'b0));  // MR1 squared off MR
    readMr();
    addRow(1'b1, macPkg::ADR_CMD, packCmd(4'b1000, 3'b000, 2'b11, 1'b0));
    readMr();
    addRow(1'b1, macPkg::ADR_MX0, 16'h8001);
    addRow(1'b1, macPkg::ADR_MY0, 16'hC000);
    addRow(1'b1, macPkg::ADR_CMD, packCmd(4'b0110, 3'b000, 2'b00, 1'b0));
    readMr();
    addRow(1'b1, macPkg::ADR_CMD, packCmd(4'b0111, 3'b000, 2'b00, 1'b0));
    readMr();
    addRow(1'b1, macPkg::ADR_MX0, 16'h4000);  // 0xC000 rounds up into MR1
    addRow(1'b1, macPkg::ADR_MY0, 16'h0003);
    addRow(1'b1, macPkg::ADR_CMD, packCmd(4'b0001, 3'b000, 2'b00, 1'b0));
    readMr();
    // a shadow command first so that the operand writes land in the shadow set
    addRow(1'b1, macPkg::ADR_CMD, packCmd(4'b0101, 3'b000, 2'b00, 1'b1));
    addRow(1'b1, macPkg::ADR_MX0, 16'h1234);
    addRow(1'b1, macPkg::ADR_MY0, 16'h0010);
    addRow(1'b1, macPkg::ADR_CMD, packCmd(4'b0101, 3'b000, 2'b00, 1'b1));
    addRow(1'b0, macPkg::ADR_MR0, '0);
    addRow(1'b0, macPkg::ADR_MR1, '0);
    addRow(1'b0, macPkg::ADR_MX0, '0);
    addRow(1'b1, macPkg::ADR_CMD, packCmd(4'b1000, 3'b000, 2'b11, 1'b0));
    readMr();
    addRow(1'b0, macPkg::ADR_MX0, '0);
    for (int g = 0; g < 4; g++) begin
      addRow(1'b1, macPkg::ADR_MX0, 16'($urandom));
      addRow(1'b1, macPkg::ADR_MX1, 16'($urandom));
      addRow(1'b1, macPkg::ADR_MY0, 16'($urandom));
      addRow(1'b1, macPkg::ADR_MY1, 16'($urandom));
      addRow(1'b1, macPkg::ADR_CMD,
             packCmd(pickAmf($urandom), pickXop($urandom), 2'($urandom), 1'b0));
      readMr();
    end
  endtask

  // one Wishbone transfer, request held until ack, then one idle cycle
  task automatic driveRow(input tableRow row);
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = row.we;
    req.adr = row.adr;
    req.dat = row.dat;
    expData = row.expData;
    do begin
      @(posedge DSPCLK);
      #2;
    end while (!rsp.ack);
    @(posedge DSPCLK);
    #2;
    req = '0;
    @(posedge DSPCLK);
    #2;
  endtask

  initial begin
    rst        = 1'b1;
    req        = '0;
    expData    = '0;
    runDone    = 1'b0;
    tableReady = 1'b0;
    void'($urandom(32'h510e4ac1));
    buildTable();
    tableReady = 1'b1;
    repeat (2) @(posedge DSPCLK);
    #2;
    rst = 1'b0;
    for (int i = 0; i < rowTable.size(); i++) begin
      driveRow(rowTable[i]);
    end
    runDone = 1'b1;
    #1;
    if (errorCount == 0 && ackCount == rowTable.size()) begin
      $display("All tests passed");
    end else begin
      if (ackCount != rowTable.size()) begin
        $display("saw %0d acknowledges for %0d table rows", ackCount, rowTable.size());
      end
      $display("Some tests failed");
    end
    $finish;
  end

  // every row fits well inside 25 clock periods
  initial begin
    wait (tableReady);
    #(rowTable.size() * 25 * 40);
    $display("watchdog expired before the table finished, the DUT stopped answering");
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- source/macAccumulator.sv
module macAccumulator (
  input  macPkg::accWord     mrIn,
  input  macPkg::productWord product,
  input  macPkg::macCtrl     ctrl,
  output macPkg::accWord     mrOut
);

  logic           prodSign;
  macPkg::accWord prodExt;
  macPkg::accWord base;
  macPkg::accWord sum;
  macPkg::accWord biased;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // product and base
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    // only an unsigned by unsigned product can use bit 31 as magnitude
    prodSign = (ctrl.unsignX && ctrl.unsignY) ? 1'b0 : product[31];
    prodExt  = {{8{prodSign}}, product};
    base     = ctrl.mzero ? '0 : mrIn;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // add or subtract, then round
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    if (ctrl.msub) begin
      sum = base - prodExt;  // wraps at 40 bits
    end else begin
      sum = base + prodExt;
    end

    biased = sum + macPkg::RND_BIAS;

    if (ctrl.rnd) begin
      mrOut = {biased[39:16], 16'h0000};  // MR0 is cleared by rounding
    end else begin
      mrOut = sum;
    end
  end

endmodule

//--- source/macDecoder.sv
module macDecoder (
  input  logic           DSPCLK,
  input  logic           rst,
  input  logic           issue,
  input  macPkg::macCmd  cmd,
  output macPkg::macCtrl ctrl
);

  macPkg::macCtrl decoded;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AMF function decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    decoded.msub  = (cmd.amf == 4'b0011) || (cmd.amf[3:2] == 2'b11);  // MR minus product forms
    decoded.mzero = (cmd.amf == 4'b0001) || (cmd.amf[3:2] == 2'b01);  // base is cleared
    decoded.rnd   = (cmd.amf[3:2] == 2'b00);                          // the whole 00xx group rounds
    // rounding forms are always signed so their low bits never mean unsigned
    decoded.unsignX = cmd.amf[1] && !decoded.rnd;
    decoded.unsignY = cmd.amf[0] && !decoded.rnd;

    case (cmd.xop)
      3'b000:  decoded.xSel = macPkg::X_MX0;
      3'b001:  decoded.xSel = macPkg::X_MX1;
      3'b011:  decoded.xSel = macPkg::X_MR0;  // MR feedback into the X side
      3'b100:  decoded.xSel = macPkg::X_MR1;
      3'b101:  decoded.xSel = macPkg::X_MR2;
      default: decoded.xSel = macPkg::X_MX0;  // unused codes fall back to MX0
    endcase

    case (cmd.yop)
      2'b00:   decoded.ySel = macPkg::Y_MY0;
      2'b01:   decoded.ySel = macPkg::Y_MY1;
      2'b10:   decoded.ySel = macPkg::Y_MR1;  // takes the place of MF here
      default: decoded.ySel = macPkg::Y_ZERO;
    endcase

    decoded.shadow = cmd.shadow;
  end

  // the decoded word stays put for the whole operation and beyond
  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      ctrl <= '0;  // primary bank, plain signed multiply
    end else if (issue) begin
      ctrl <= decoded;
    end
  end

  // an unknown Xop would quietly fall back to MX0 instead of a real X source
  cmdKnownAtIssue: assert property (@(posedge DSPCLK) disable iff (rst)
    issue |-> !$isunknown(cmd));

endmodule

//--- source/macMultiplier.sv
module macMultiplier (
  input  logic               DSPCLK,
  input  logic               rst,
  input  logic               start,
  input  macPkg::dataWord    xOp,
  input  macPkg::dataWord    yOp,
  input  logic               unsignX,
  input  logic               unsignY,
  output macPkg::productWord product
);

  logic [16:0]        xExt;      // operands widened by one sign bit
  logic [16:0]        yExt;
  logic signed [19:0] xWide;
  logic signed [19:0] addend;
  logic signed [19:0] sum;
  logic signed [19:0] hiAcc;     // upper partial product
  macPkg::dataWord    loAcc;     // retired low bits shift in from the top
  macPkg::dataWord    stepMask;  // one hot, picks the multiplier bit of this cycle
  logic               yBit;

  // an unsigned operand gets a zero on top, a signed one repeats its MSB
  assign xExt = {xOp[15] && !unsignX, xOp};
  assign yExt = {yOp[15] && !unsignY, yOp};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one shift-add step
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    xWide  = {{3{xExt[16]}}, xExt};
    yBit   = |(yOp & stepMask);
    addend = yBit ? xWide : '0;
    // a negative multiplier carries weight -2^16, which is twice the last bit weight
    if (stepMask[15] && yExt[16]) begin
      addend = addend - (xWide <<< 1);
    end
    sum = hiAcc + addend;
  end

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      stepMask <= '0;
    end else if (start) begin
      stepMask <= 16'h0001;
    end else begin
      stepMask <= stepMask << 1;  // empties itself after the sixteenth step
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (start) begin
      hiAcc <= '0;
      loAcc <= '0;
    end else if (|stepMask) begin
      hiAcc <= sum >>> 1;
      loAcc <= {sum[0], loAcc[15:1]};
    end
  end

  assign product = {hiAcc[15:0], loAcc};  // stable from the WRITEBACK cycle on

endmodule

//--- source/macPkg.sv
package macPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // word widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [15:0] dataWord;     // operand registers and the bus word
  typedef logic [31:0] productWord;  // full multiplier output
  typedef logic [39:0] accWord;      // MR2:MR1:MR0 packed as one value
  typedef logic [2:0]  regAddr;      // Wishbone word address

  localparam int MUL_STEPS = 16;                 // one multiplier bit per cycle
  localparam int STEP_W    = $clog2(MUL_STEPS);  // width of the step counter
  localparam int NUM_BANKS = 2;                  // primary and shadow
  localparam accWord RND_BIAS = 40'h00_0000_8000;  // half an LSB of MR1

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam regAddr ADR_MX0 = 3'd0;
  localparam regAddr ADR_MX1 = 3'd1;
  localparam regAddr ADR_MY0 = 3'd2;
  localparam regAddr ADR_MY1 = 3'd3;
  localparam regAddr ADR_CMD = 3'd4;  // writing here starts an operation
  localparam regAddr ADR_MR0 = 3'd5;
  localparam regAddr ADR_MR1 = 3'd6;
  localparam regAddr ADR_MR2 = 3'd7;  // read back sign extended from 8 bits

  // X operand sources use the Xop code as their encoding
  typedef enum logic [2:0] {
    X_MX0 = 3'b000,
    X_MX1 = 3'b001,
    X_MR0 = 3'b011,
    X_MR1 = 3'b100,
    X_MR2 = 3'b101
  } xSource;

  typedef enum logic [1:0] {
    Y_MY0  = 2'b00,
    Y_MY1  = 2'b01,
    Y_MR1  = 2'b10,
    Y_ZERO = 2'b11
  } ySource;

  typedef enum logic [2:0] {IDLE, ISSUE, MULTIPLY, WRITEBACK, ACK} seqState;

  // low ten bits of a CMD write
  typedef struct packed {
    logic [3:0] amf;
    logic [2:0] xop;
    logic [1:0] yop;
    logic       shadow;
  } macCmd;

  typedef struct packed {
    logic   msub;
    logic   mzero;
    logic   rnd;
    logic   unsignX;
    logic   unsignY;
    xSource xSel;
    ySource ySel;
    logic   shadow;
  } macCtrl;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    regAddr  adr;
    dataWord dat;
  } wbReq;

  typedef struct packed {
    logic    ack;
    dataWord dat;
  } wbRsp;

endpackage

//--- source/macRegFile.sv
module macRegFile (
  input  logic            DSPCLK,
  input  logic            rst,
  input  macPkg::wbReq    req,
  input  logic            regWrite,
  input  logic            writeBack,
  input  macPkg::macCtrl  ctrl,
  input  macPkg::accWord  mrNew,
  output macPkg::dataWord xOp,
  output macPkg::dataWord yOp,
  output macPkg::accWord  mrCur,
  output macPkg::dataWord rdData
);

  macPkg::dataWord mx0 [macPkg::NUM_BANKS];
  macPkg::dataWord mx1 [macPkg::NUM_BANKS];
  macPkg::dataWord my0 [macPkg::NUM_BANKS];
  macPkg::dataWord my1 [macPkg::NUM_BANKS];
  macPkg::accWord  mr  [macPkg::NUM_BANKS];
  macPkg::macCmd   cmdReg;  // last command word, for readback only
  macPkg::dataWord mr2Word;
  logic            bank;

  assign bank = ctrl.shadow;  // 1 selects the shadow set

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register banks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      for (int b = 0; b < macPkg::NUM_BANKS; b++) begin
        mx0[b] <= '0;
        mx1[b] <= '0;
        my0[b] <= '0;
        my1[b] <= '0;
        mr[b]  <= '0;
      end
      cmdReg <= '0;
    end else begin
      if (regWrite) begin
        case (req.adr)
          macPkg::ADR_MX0: mx0[bank] <= req.dat;
          macPkg::ADR_MX1: mx1[bank] <= req.dat;
          macPkg::ADR_MY0: my0[bank] <= req.dat;
          macPkg::ADR_MY1: my1[bank] <= req.dat;
          macPkg::ADR_CMD: cmdReg    <= macPkg::macCmd'(req.dat[9:0]);
          default: ;  // MR is written by the datapath only
        endcase
      end
      if (writeBack) begin
        mr[bank] <= mrNew;
      end
    end
  end

  assign mrCur   = mr[bank];
  assign mr2Word = {{8{mrCur[39]}}, mrCur[39:32]};  // MR2 seen as a full word

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand and readback muxes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (ctrl.xSel)
      macPkg::X_MX1: xOp = mx1[bank];
      macPkg::X_MR0: xOp = mrCur[15:0];
      macPkg::X_MR1: xOp = mrCur[31:16];
      macPkg::X_MR2: xOp = mr2Word;
      default:       xOp = mx0[bank];
    endcase

    case (ctrl.ySel)
      macPkg::Y_MY0: yOp = my0[bank];
      macPkg::Y_MY1: yOp = my1[bank];
      macPkg::Y_MR1: yOp = mrCur[31:16];
      default:       yOp = '0;  // leaves the base unchanged
    endcase

    case (req.adr)
      macPkg::ADR_MX0: rdData = mx0[bank];
      macPkg::ADR_MX1: rdData = mx1[bank];
      macPkg::ADR_MY0: rdData = my0[bank];
      macPkg::ADR_MY1: rdData = my1[bank];
      macPkg::ADR_CMD: rdData = {6'b0, cmdReg};
      macPkg::ADR_MR0: rdData = mrCur[15:0];
      macPkg::ADR_MR1: rdData = mrCur[31:16];
      default:         rdData = mr2Word;
    endcase
  end

endmodule

//--- source/macSequencer.sv
module macSequencer (
  input  logic         DSPCLK,
  input  logic         rst,
  input  macPkg::wbReq req,
  output logic         ack,
  output logic         issue,
  output logic         start,
  input  logic         lastStep,
  output logic         writeBack,
  output logic         regWrite,
  output logic         isCmd
);

  macPkg::seqState state;
  macPkg::seqState nextState;
  logic            reqValid;

  assign reqValid = req.cyc && req.stb;  // classic cycle, no pipelining
  assign isCmd    = reqValid && req.we && (req.adr == macPkg::ADR_CMD);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      state <= macPkg::IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      macPkg::IDLE: begin
        if (reqValid) begin
          // only a command write runs the datapath, everything else answers at once
          nextState = isCmd ? macPkg::ISSUE : macPkg::ACK;
        end
      end
      macPkg::ISSUE: begin
        nextState = macPkg::MULTIPLY;  // decoder and multiplier load here
      end
      macPkg::MULTIPLY: begin
        if (lastStep) begin
          nextState = macPkg::WRITEBACK;
        end
      end
      macPkg::WRITEBACK: begin
        nextState = macPkg::ACK;
      end
      macPkg::ACK: begin
        nextState = macPkg::IDLE;  // master drops stb after seeing ack
      end
      default: begin
        nextState = macPkg::IDLE;
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // strobes decoded from the state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign issue     = (state == macPkg::ISSUE);
  assign start     = (state == macPkg::ISSUE);      // counter and multiplier clear together
  assign writeBack = (state == macPkg::WRITEBACK);  // MR updates at the end of this cycle
  assign ack       = (state == macPkg::ACK);
  // host writes land on the acknowledge edge, so a command word is kept for readback too
  assign regWrite  = (state == macPkg::ACK) && req.we;

  // the master must still be strobing when the answer comes back
  ackInsideStb: assert property (@(posedge DSPCLK) disable iff (rst)
    ack |-> req.stb);

endmodule

//--- source/macStepCounter.sv
module macStepCounter (
  input  logic DSPCLK,
  input  logic rst,
  input  logic start,
  output logic lastStep
);

  logic [macPkg::STEP_W-1:0] count;
  logic                      running;

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      count   <= '0;
      running <= 1'b0;
    end else if (start) begin
      count   <= macPkg::STEP_W'(macPkg::MUL_STEPS - 1);  // counts down to zero
      running <= 1'b1;
    end else if (running) begin
      count <= count - 1'b1;
      if (count == '0) begin
        running <= 1'b0;  // the zero cycle was the final step
      end
    end
  end

  assign lastStep = running && (count == '0);

  // a new multiply only starts once the previous count has run out
  noRestart: assert property (@(posedge DSPCLK) disable iff (rst)
    start |-> !running);

endmodule

//--- source/macTop.sv
module macTop (
  input  logic         DSPCLK,
  input  logic         rst,
  input  macPkg::wbReq req,
  output macPkg::wbRsp rsp
);

  macPkg::macCtrl     ctrl;
  macPkg::dataWord    xOp;
  macPkg::dataWord    yOp;
  macPkg::productWord product;
  macPkg::accWord     mrCur;
  macPkg::accWord     mrNew;
  logic               issue;
  logic               start;
  logic               lastStep;
  logic               writeBack;
  logic               regWrite;

  macSequencer sequencerInst (
    .DSPCLK(DSPCLK), .rst(rst), .req(req), .ack(rsp.ack), .issue(issue),
    .start(start), .lastStep(lastStep), .writeBack(writeBack),
    .regWrite(regWrite), .isCmd()
  );

  // the command fields sit in the low bits of the bus word
  macDecoder decoderInst (
    .DSPCLK(DSPCLK), .rst(rst), .issue(issue),
    .cmd(macPkg::macCmd'(req.dat[9:0])), .ctrl(ctrl)
  );

  macStepCounter stepCounterInst (
    .DSPCLK(DSPCLK), .rst(rst), .start(start), .lastStep(lastStep)
  );

  macMultiplier multiplierInst (
    .DSPCLK(DSPCLK), .rst(rst), .start(start), .xOp(xOp), .yOp(yOp),
    .unsignX(ctrl.unsignX), .unsignY(ctrl.unsignY), .product(product)
  );

  macAccumulator accumulatorInst (
    .mrIn(mrCur), .product(product), .ctrl(ctrl), .mrOut(mrNew)
  );

  macRegFile regFileInst (
    .DSPCLK(DSPCLK), .rst(rst), .req(req), .regWrite(regWrite),
    .writeBack(writeBack), .ctrl(ctrl), .mrNew(mrNew), .xOp(xOp),
    .yOp(yOp), .mrCur(mrCur), .rdData(rsp.dat)
  );

endmodule
